/* hw/acp_defs.svh */
`ifndef ACP_DEFS_SVH
`define ACP_DEFS_SVH

//////////////////////////////
// Sizes
//////////////////////////////

// Tone channels in the core
`define ACP_NUM_CH 4

// Host register word
`define ACP_DATA_W 16

// Register address field, m_bus_in[19:16]
`define ACP_ADDR_LSB 16
`define ACP_ADDR_W 4

//////////////////////////////
// Register map
//////////////////////////////

// Channel k note word at 2k, effects word at 2k+1
`define ACP_ADDR_NOTE(k) (`ACP_ADDR_W'(2 * (k)))
`define ACP_ADDR_FX(k) (`ACP_ADDR_W'(2 * (k) + 1))

// Master volume shift, low two data bits
`define ACP_ADDR_VOL (`ACP_ADDR_W'(8))

// Clocks per note tick, 50 MHz / 390625 = 128 Hz
`define ACP_TICK_DIV 390625

`endif

/* hw/acp_pkg.sv */
package acp_pkg;

	// Waveform select, effects word bits 1:0
	typedef enum logic [1:0] {
		wave_square   = 2'd0,
		wave_triangle = 2'd1,
		wave_noise    = 2'd2,
		wave_off      = 2'd3
	} wave_e;

	// Note view of a channel word
	typedef struct packed {
		logic [5:0] rsvd;
		logic       gate;
		// Note ticks, 0 holds until the next write
		logic [2:0] length;
		logic [1:0] octave;
		logic [3:0] pitch;
	} note_word_t;

	// Effects view of a channel word
	typedef struct packed {
		logic [9:0] rsvd;
		logic [1:0] decay;
		logic [1:0] attack;
		wave_e      wave;
	} fx_word_t;

	// One stored register, read in either view
	typedef union packed {
		note_word_t note;
		fx_word_t   fx;
	} ch_word_u;

	// Half-periods in 50 MHz clocks, C5 up to D#6
	localparam logic [15:0] pitch_base [0:15] = '{
		16'd47778, 16'd45097, 16'd42566, 16'd40177,
		16'd37922, 16'd35793, 16'd33784, 16'd31888,
		16'd30098, 16'd28409, 16'd26815, 16'd25310,
		16'd23889, 16'd22548, 16'd21283, 16'd20088
	};

endpackage

/* hw/acp_regfile.sv */
`include "acp_defs.svh"

module acp_regfile #(
	parameter int TICK_DIV = `ACP_TICK_DIV
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [31:0]              m_bus_in,
	input  logic                     m_ack,
	output acp_pkg::ch_word_u        note_word [`ACP_NUM_CH],
	output acp_pkg::ch_word_u        fx_word [`ACP_NUM_CH],
	output logic [`ACP_NUM_CH-1:0]   start,
	output logic                     tick,
	output logic [1:0]               master_vol,
	output logic [`ACP_ADDR_W-1:0]   last_addr
);

	// Address and data fields of the current bus word
	logic [`ACP_ADDR_W-1:0] wr_addr;
	acp_pkg::ch_word_u wr_data;
	// Gated note words stored at the last edge
	logic [`ACP_NUM_CH-1:0] gate_wr;
	logic [31:0] tick_cnt;

	assign wr_addr = m_bus_in[`ACP_ADDR_LSB +: `ACP_ADDR_W];
	assign wr_data = m_bus_in[`ACP_DATA_W-1:0];

	//////////////////////////////
	// Host write decode
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < `ACP_NUM_CH; k++)
			begin
				note_word[k] <= '0;
				fx_word[k] <= '0;
			end
			gate_wr <= '0;
			start <= '0;
			master_vol <= '0;
			last_addr <= '0;
		end
		else
		begin
			for (int k = 0; k < `ACP_NUM_CH; k++)
			begin
				// Gated note write, voice restarts once the word is stored
				gate_wr[k] <= m_ack && (wr_addr == `ACP_ADDR_NOTE(k)) && wr_data.note.gate;
				if (m_ack && (wr_addr == `ACP_ADDR_NOTE(k)))
					note_word[k] <= wr_data;
				if (m_ack && (wr_addr == `ACP_ADDR_FX(k)))
					fx_word[k] <= wr_data;
			end
			// Start pulse in the cycle after the note word lands
			start <= gate_wr;
			if (m_ack && (wr_addr == `ACP_ADDR_VOL))
				master_vol <= wr_data[1:0];
			// Any strobe, mapped or not
			if (m_ack)
				last_addr <= wr_addr;
		end
	end

	//////////////////////////////
	// Note tick divider
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tick_cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// One pulse per TICK_DIV clocks
			tick <= (tick_cnt == 32'(TICK_DIV - 1));
			if (tick_cnt == 32'(TICK_DIV - 1))
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 32'd1;
		end
	end

endmodule

/* hw/tone_channel.sv */
module tone_channel (
	input  logic              clk,
	input  logic              rst_n,
	input  acp_pkg::ch_word_u note_word,
	input  acp_pkg::ch_word_u fx_word,
	input  logic              start,
	input  logic              tick,
	output logic [3:0]        level,
	output logic              active
);

	logic [15:0] half_period;
	logic [15:0] div_cnt;
	logic step;
	logic sq_phase;
	logic [3:0] tri_phase;
	logic tri_up;
	logic [14:0] lfsr;
	logic [3:0] wave_lvl;
	logic [3:0] env;
	logic env_rise;
	logic [4:0] atk_step;
	logic [4:0] dec_step;
	logic [2:0] len_cnt;
	logic [8:0] scaled;

	//////////////////////////////
	// Pitch divider
	//////////////////////////////

	// Each octave halves the period
	assign half_period = acp_pkg::pitch_base[note_word.note.pitch] >> note_word.note.octave;
	assign step = active && (div_cnt == 16'd0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			sq_phase <= 1'b0;
			tri_phase <= '0;
			tri_up <= 1'b1;
			lfsr <= 15'h0001;
		end
		else if (start)
		begin
			div_cnt <= half_period - 16'd1;
			sq_phase <= 1'b1;
			tri_phase <= '0;
			tri_up <= 1'b1;
		end
		else if (step)
		begin
			div_cnt <= half_period - 16'd1;
			sq_phase <= ~sq_phase;
			// Triangle bounces between 0 and 15
			if (tri_up)
			begin
				tri_up <= (tri_phase != 4'd14);
				tri_phase <= tri_phase + 4'd1;
			end
			else
			begin
				tri_up <= (tri_phase == 4'd1);
				tri_phase <= tri_phase - 4'd1;
			end
			// x^15 + x^14 + 1
			lfsr <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};
		end
		else if (active)
			div_cnt <= div_cnt - 16'd1;
	end

	// Raw waveform sample
	always_comb
	begin
		case (fx_word.fx.wave)
			acp_pkg::wave_square:   wave_lvl = {4{sq_phase}};
			acp_pkg::wave_triangle: wave_lvl = tri_phase;
			acp_pkg::wave_noise:    wave_lvl = {4{lfsr[0]}};
			default:                wave_lvl = 4'd0;
		endcase
	end

	//////////////////////////////
	// Envelope and length
	//////////////////////////////

	// Rates 1..3 step by 1, 2, 4 per tick
	assign atk_step = 5'd1 << (fx_word.fx.attack - 2'd1);
	assign dec_step = 5'd1 << (fx_word.fx.decay - 2'd1);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			env <= '0;
			env_rise <= 1'b0;
			len_cnt <= '0;
			active <= 1'b0;
		end
		else if (start)
		begin
			// Attack 0 means full level at once
			env <= (fx_word.fx.attack == 2'd0) ? 4'd15 : 4'd0;
			env_rise <= (fx_word.fx.attack != 2'd0);
			len_cnt <= note_word.note.length;
			active <= 1'b1;
		end
		else if (!note_word.note.gate)
			active <= 1'b0;
		else if (tick && active)
		begin
			if (env_rise)
			begin
				env <= ({1'b0, env} + atk_step >= 5'd15) ? 4'd15 : env + atk_step[3:0];
				env_rise <= ({1'b0, env} + atk_step < 5'd15);
			end
			else if (fx_word.fx.decay != 2'd0)
				env <= ({1'b0, env} <= dec_step) ? 4'd0 : env - dec_step[3:0];
			// Length 0 sustains
			if (len_cnt != 3'd0)
			begin
				len_cnt <= len_cnt - 3'd1;
				active <= (len_cnt != 3'd1);
			end
		end
	end

	// Full envelope passes the wave unchanged
	assign scaled = wave_lvl * ({1'b0, env} + 5'd1);
	assign level = (active && fx_word.fx.wave != acp_pkg::wave_off) ? scaled[7:4] : 4'd0;

endmodule

/* hw/acp_mixer.sv */
`include "acp_defs.svh"

module acp_mixer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [3:0]             level [`ACP_NUM_CH],
	input  logic [`ACP_NUM_CH-1:0] active,
	input  logic [`ACP_NUM_CH-1:0] mute,
	input  logic [1:0]             master_vol,
	output logic [7:0]             audio_out
);

	// Up to 4 x 15 = 60
	logic [5:0] mix_sum;
	// Up to 60 << 3 = 480
	logic [8:0] mix_scaled;

	//////////////////////////////
	// Sum and scale
	//////////////////////////////

	always_comb
	begin
		mix_sum = '0;
		for (int k = 0; k < `ACP_NUM_CH; k++)
		begin
			// Muted or idle voices drop out
			if (active[k] && !mute[k])
				mix_sum = mix_sum + 6'(level[k]);
		end
		mix_scaled = 9'(mix_sum) << master_vol;
	end

	// Clip at full scale
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			audio_out <= '0;
		else if (mix_scaled[8])
			audio_out <= 8'hff;
		else
			audio_out <= mix_scaled[7:0];
	end

endmodule

/* hw/acp.sv */
`include "acp_defs.svh"

module acp #(
	parameter int TICK_DIV = `ACP_TICK_DIV
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] m_bus_in,
	input  logic        m_ack,
	input  logic [7:0]  m_ctrl_in,
	output logic [7:0]  m_ctrl_out,
	output logic [7:0]  audio_out
);

	acp_pkg::ch_word_u note_word [`ACP_NUM_CH];
	acp_pkg::ch_word_u fx_word [`ACP_NUM_CH];
	logic [`ACP_NUM_CH-1:0] start;
	logic tick;
	logic [1:0] master_vol;
	logic [`ACP_ADDR_W-1:0] last_addr;
	logic [3:0] level [`ACP_NUM_CH];
	logic [`ACP_NUM_CH-1:0] active;

	// Status nibble pair back to the host
	assign m_ctrl_out = {last_addr, active};

	acp_regfile #(.TICK_DIV(TICK_DIV)) u_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.m_bus_in   (m_bus_in),
		.m_ack      (m_ack),
		.note_word  (note_word),
		.fx_word    (fx_word),
		.start      (start),
		.tick       (tick),
		.master_vol (master_vol),
		.last_addr  (last_addr)
	);

	//////////////////////////////
	// Voices
	//////////////////////////////

	for (genvar k = 0; k < `ACP_NUM_CH; k++)
	begin : g_ch
		tone_channel u_ch (
			.clk       (clk),
			.rst_n     (rst_n),
			.note_word (note_word[k]),
			.fx_word   (fx_word[k]),
			.start     (start[k]),
			.tick      (tick),
			.level     (level[k]),
			.active    (active[k])
		);
	end

	// Mutes are the low control bits
	acp_mixer u_mixer (
		.clk        (clk),
		.rst_n      (rst_n),
		.level      (level),
		.active     (active),
		.mute       (m_ctrl_in[3:0]),
		.master_vol (master_vol),
		.audio_out  (audio_out)
	);

endmodule

/* verif/clk_gen.sv */
module clk_gen #(
	parameter int PERIOD = 100,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	// Free-running clock, low at time zero
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first edges, dropped on a falling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* verif/acp_tb.sv */
`include "acp_defs.svh"

module acp_tb #(
	parameter int TICK_DIV = `ACP_TICK_DIV
);

	localparam int PERIOD = 100;
	// Columns per vector line
	localparam int NF = 10;
	localparam int MAX_TESTS = 32;
	// Empty write slot
	localparam logic [31:0] NO_WRITE = 32'h000fffff;

	// Test kinds, first column
	localparam int OP_OBSERVE = 0;
	localparam int OP_START = 1;
	localparam int OP_SQUARE = 2;
	localparam int OP_LENGTH = 3;
	localparam int OP_SHAPE = 4;

	logic clk;
	logic rst_n;
	logic [31:0] m_bus_in;
	logic m_ack;
	logic [7:0] m_ctrl_in;
	logic [7:0] m_ctrl_out;
	logic [7:0] audio_out;

	logic [31:0] vec [NF * MAX_TESTS];
	integer seed;
	int limit_clk;
	// Results of one observation window
	logic [7:0] peak;
	logic [15:0] seen;
	int rises;

	clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(3)) u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	acp #(.TICK_DIV(TICK_DIV)) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.m_bus_in   (m_bus_in),
		.m_ack      (m_ack),
		.m_ctrl_in  (m_ctrl_in),
		.m_ctrl_out (m_ctrl_out),
		.audio_out  (audio_out)
	);

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch at %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, exp));
	endtask

	//////////////////////////////
	// Bus driving
	//////////////////////////////

	// Random idle gap, then one strobe cycle; returns on a falling edge
	task automatic bus_write(input logic [31:0] word);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(negedge clk);
		m_bus_in = word;
		m_ack = 1'b1;
		@(negedge clk);
		m_ack = 1'b0;
		m_bus_in = '0;
	endtask

	// All notes ungated, effects and volume back to zero
	task automatic silence_all();
		for (int k = 0; k < `ACP_NUM_CH; k++)
		begin
			bus_write({12'h0, `ACP_ADDR_NOTE(k), 16'h0000});
			bus_write({12'h0, `ACP_ADDR_FX(k), 16'h0000});
		end
		bus_write({12'h0, `ACP_ADDR_VOL, 16'h0000});
	endtask

	//////////////////////////////
	// Observation
	//////////////////////////////

	// Peak, levels seen and rising edges over a window of clocks
	task automatic observe(input int win, input int op, input logic [31:0] half);
		int last_rise;
		logic [7:0] prev;
		peak = '0;
		seen = '0;
		rises = 0;
		last_rise = 0;
		prev = audio_out;
		for (int c = 1; c <= win; c++)
		begin
			@(negedge clk);
			if (audio_out > peak)
				peak = audio_out;
			if (audio_out < 8'd16)
				seen[audio_out[3:0]] = 1'b1;
			if (audio_out != 8'd0 && prev == 8'd0)
			begin
				rises++;
				// Full period is two half-periods
				if (op == OP_SQUARE && rises > 1)
					check_val("square rise spacing", 32'(c - last_rise), 2 * half);
				last_rise = c;
			end
			prev = audio_out;
			if (op == OP_SQUARE && rises == 3)
				break;
		end
	endtask

	// Clocks from start until the active bits drop
	task automatic measure_length(input int len, input logic [31:0] exp_after);
		int cnt;
		int limit;
		limit = (len + 2) * TICK_DIV;
		// Active bit shows two edges after the write
		@(negedge clk);
		@(negedge clk);
		cnt = 1;
		check_val("active after start", 32'(m_ctrl_out[3:0] != 4'h0), 1);
		while (m_ctrl_out[3:0] != 4'h0 && cnt < limit)
		begin
			@(negedge clk);
			cnt++;
		end
		if (m_ctrl_out[3:0] != 4'h0)
			stop_run($sformatf("Channel still active %0d clocks after a length %0d note",
				cnt, len));
		// Within one tick of length x divider
		check_val("active fall window",
			32'((cnt >= (len - 1) * TICK_DIV) && (cnt <= (len + 1) * TICK_DIV)), 1);
		@(negedge clk);
		check_val("audio_out after note end", audio_out, exp_after);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int base;
		int op;
		int ntests;
		int len_sum;
		int budget;
		logic [31:0] w;
		m_bus_in = '0;
		m_ack = 1'b0;
		m_ctrl_in = '0;
		seed = 32'h1292c741;
		for (int i = 0; i < NF * MAX_TESTS; i++)
			vec[i] = '1;
		$readmemh("verif/acp_vectors.txt", vec);

		// Count tests and size the watchdog from windows and note lengths
		ntests = 0;
		budget = 1000;
		while (ntests < MAX_TESTS && vec[ntests * NF] != '1)
		begin
			base = ntests * NF;
			len_sum = 0;
			for (int k = 2; k < 7; k++)
			begin
				w = vec[base + k];
				// Even address below 8 is a note word
				if (w != NO_WRITE && w[16] == 1'b0 && w[19:16] < 4'd8)
					len_sum += int'(w[8:6]);
			end
			budget += int'(vec[base + 7]) + (len_sum + 2) * TICK_DIV + 100;
			ntests++;
		end
		limit_clk = budget;

		@(posedge rst_n);
		@(negedge clk);
		for (int t = 0; t < ntests; t++)
		begin
			base = t * NF;
			op = int'(vec[base]);
			m_ctrl_in = vec[base + 1][7:0];
			// Tests without writes see the state left by reset
			if (vec[base + 2] != NO_WRITE)
				silence_all();
			for (int k = 2; k < 7; k++)
			begin
				if (vec[base + k] != NO_WRITE)
					bus_write(vec[base + k]);
			end
			case (op)
				OP_OBSERVE:
				begin
					observe(int'(vec[base + 7]), op, 0);
					check_val("audio_out peak", peak, vec[base + 8]);
					check_val("m_ctrl_out", m_ctrl_out, vec[base + 9]);
				end
				OP_START:
				begin
					// Address shows at once, active bit two edges after the write
					check_val("m_ctrl_out at write edge", m_ctrl_out,
						{vec[base + 8][7:4], 4'h0});
					@(negedge clk);
					check_val("m_ctrl_out one edge after write", m_ctrl_out,
						{vec[base + 8][7:4], 4'h0});
					@(negedge clk);
					check_val("m_ctrl_out two edges after write", m_ctrl_out, vec[base + 8]);
				end
				OP_SQUARE:
				begin
					observe(int'(vec[base + 7]), op, vec[base + 8]);
					if (rises < 3)
						stop_run($sformatf("Square wave gave %0d rising edges in %0d clocks",
							rises, vec[base + 7]));
					check_val("square levels seen", seen, vec[base + 9]);
					// Single full-level voice at volume 0
					check_val("square peak", peak, 8'd15);
				end
				OP_LENGTH:
					measure_length(int'(vec[base + 8]), vec[base + 9]);
				OP_SHAPE:
				begin
					observe(int'(vec[base + 7]), op, 0);
					check_val("levels seen", seen, vec[base + 8]);
					check_val("audio_out peak", peak, vec[base + 9]);
				end
				default:
					stop_run($sformatf("Unknown test kind %0d in vector %0d", op, t));
			endcase
		end

		if (ntests > 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
			stop_run("No test vectors were read");
	end

	// Watchdog, armed once the budget is known
	initial
	begin
		wait (limit_clk > 0);
		#(64'(limit_clk) * PERIOD);
		stop_run($sformatf("Watchdog expired after %0d clocks", limit_clk));
	end

endmodule

/* verif/acp_vectors.txt */
// kind ctrl write0..write4 (addr nibble + data word, fffff empty) window exp_a exp_b
// kinds 0 observe, 1 start, 2 square, 3 length, 4 shape
0 00 fffff fffff fffff fffff fffff 0014 00 00
0 00 10001 30002 50003 70014 fffff 0100 00 70
1 00 00239 fffff fffff fffff fffff 0000 01 00
1 00 40200 fffff fffff fffff fffff 0000 44 00
1 00 80001 70001 60285 fffff fffff 0000 68 00
2 00 80000 00239 fffff fffff fffff 4000 0ddf 8001
2 00 80000 2022f fffff fffff fffff 5400 139e 8001
2 00 80000 60230 fffff fffff fffff 6000 1754 8001
2 00 80000 4023c fffff fffff fffff 3400 0baa 8001
3 00 002c9 fffff fffff fffff fffff 0000 3 00
3 00 203ff fffff fffff fffff fffff 0000 7 00
3 00 50008 40241 fffff fffff fffff 0000 1 00
0 04 80002 00239 2022f 4023c fffff 0100 78 47
0 00 80003 50003 00239 2022f 4023c 0100 f0 47
0 00 80003 00239 2022f 4023c 60230 0100 ff 6f
0 08 80001 00239 2022f 4023c 60230 0100 5a 6f
4 00 80000 30001 2023f fffff fffff a000 ffff 0f
4 00 80000 70002 6023f fffff fffff c000 8001 0f

/* tb.f */
+incdir+hw
hw/acp_pkg.sv
hw/acp_regfile.sv
hw/tone_channel.sv
hw/acp_mixer.sv
hw/acp.sv
verif/clk_gen.sv
verif/acp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= acp_tb
FILELIST ?= tb.f
TICK_DIV ?= 64
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= TEST PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, and pass only when the pass line shows in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GTICK_DIV=$(TICK_DIV) --Mdir $(OBJ_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
